/* design/cgra_pe.sv */
// ========================================
// CGRA processing element
// Decodes one configuration frame per
// accepted cycle and connects the register
// file, scratchpad, operand select, ALU and
// output stage
// ========================================

`timescale 1ns/1ps

module cgra_pe #(
    parameter int SPM_DEPTH = 256
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cgra_pkg::cfg_frame_t    config_frame,
    input  logic                    config_valid,
    input  cgra_pkg::pe_word_u      data_in_n,
    input  cgra_pkg::pe_word_u      data_in_e,
    input  cgra_pkg::pe_word_u      data_in_s,
    input  cgra_pkg::pe_word_u      data_in_w,
    input  logic                    valid_in_n,
    input  logic                    valid_in_e,
    input  logic                    valid_in_s,
    input  logic                    valid_in_w,
    output cgra_pkg::pe_word_u      data_out_n,
    output cgra_pkg::pe_word_u      data_out_e,
    output cgra_pkg::pe_word_u      data_out_s,
    output cgra_pkg::pe_word_u      data_out_w,
    output cgra_pkg::pe_word_u      data_out_local,
    output logic                    valid_out_n,
    output logic                    valid_out_e,
    output logic                    valid_out_s,
    output logic                    valid_out_w,
    output logic                    valid_out_local,
    input  logic                    ready_in,
    output logic                    ready_out
);
    import cgra_pkg::*;

    localparam int SPM_AW = $clog2(SPM_DEPTH);

    logic                  accept;
    logic                  stall;
    logic [DATA_WIDTH-1:0] rf_rdata0;
    logic [DATA_WIDTH-1:0] rf_rdata1;
    logic [DATA_WIDTH-1:0] spm_rdata;
    logic [DATA_WIDTH-1:0] operand0;
    logic [DATA_WIDTH-1:0] operand1;
    logic [DATA_WIDTH-1:0] alu_result;
    logic                  exec_en;
    logic                  rf_we;
    logic                  spm_we;
    pe_word_u [3:0]        nbr_data;
    logic [3:0]            nbr_valid;
    pe_result_t            result;
    pe_word_u              out_word;
    route_mask_t           out_valid;

    // Router ready is the only stall source
    assign ready_out = ready_in;
    assign stall     = !ready_in;
    assign accept    = config_valid && ready_in;

    assign nbr_data  = {data_in_w, data_in_s, data_in_e, data_in_n};
    assign nbr_valid = {valid_in_w, valid_in_s, valid_in_e, valid_in_n};

    // ========================================
    // Units
    // ========================================
    pe_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr0 (config_frame.src0),
        .raddr1 (config_frame.src1),
        .waddr  (config_frame.dst),
        .we     (rf_we),
        .wdata  (alu_result),
        .rdata0 (rf_rdata0),
        .rdata1 (rf_rdata1)
    );

    pe_scratchpad #(
        .SPM_DEPTH (SPM_DEPTH)
    ) u_scratchpad (
        .clk   (clk),
        .addr  (config_frame.imm[SPM_AW-1:0]),
        .we    (spm_we),
        .wdata (operand0),
        .rdata (spm_rdata)
    );

    pe_operand_select u_operand_select (
        .src0      (config_frame.src0),
        .src1      (config_frame.src1),
        .imm       (config_frame.imm),
        .nbr_data  (nbr_data),
        .nbr_valid (nbr_valid),
        .rf_rdata0 (rf_rdata0),
        .rf_rdata1 (rf_rdata1),
        .spm_rdata (spm_rdata),
        .operand0  (operand0),
        .operand1  (operand1)
    );

    pe_alu u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .op        (config_frame.op),
        .pred_en   (config_frame.pred_en),
        .pred_inv  (config_frame.pred_inv),
        .operand0  (operand0),
        .operand1  (operand1),
        .spm_rdata (spm_rdata),
        .result    (alu_result),
        .exec_en   (exec_en),
        .rf_we     (rf_we),
        .spm_we    (spm_we)
    );

    always_comb begin
        result.result    = alu_result;
        result.route     = config_frame.route;
        result.multicast = config_frame.multicast;
        result.dest_x    = config_frame.dest_x;
        result.dest_y    = config_frame.dest_y;
        result.valid     = config_valid;
    end

    pe_route_out u_route_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .exec_en   (exec_en),
        .stall     (stall),
        .result_in (result),
        .data_out  (out_word),
        .valid_out (out_valid)
    );

    // Same packet on every port, valids pick the destinations
    assign data_out_n      = out_word;
    assign data_out_e      = out_word;
    assign data_out_s      = out_word;
    assign data_out_w      = out_word;
    assign data_out_local  = out_word;
    assign valid_out_n     = out_valid.n;
    assign valid_out_e     = out_valid.e;
    assign valid_out_s     = out_valid.s;
    assign valid_out_w     = out_valid.w;
    assign valid_out_local = out_valid.loc;

endmodule

/* design/cgra_pkg.sv */
// ========================================
// CGRA processing element shared types
// Widths, opcodes, operand sources, the
// configuration frame, the packet word and
// the registered result
// ========================================

package cgra_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int PAYLOAD_WIDTH = 16;
    localparam int COORD_WIDTH   = 4;
    localparam int ACC_WIDTH     = 40;
    localparam int SHAMT_WIDTH   = 4;
    localparam int RF_ADDR_WIDTH = 4;

    // Header bits left over after multicast and coordinates
    localparam int HDR_RSVD_WIDTH = DATA_WIDTH - PAYLOAD_WIDTH - 2 * COORD_WIDTH - 1;

    // 32-bit signed limits, held at accumulator width
    localparam logic signed [ACC_WIDTH-1:0] SAT_MAX = 40'sd2147483647;
    localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = -40'sd2147483648;

    typedef enum logic [5:0] {
        OP_NOP     = 6'd0,
        OP_ADD     = 6'd1,
        OP_SUB     = 6'd2,
        OP_MUL     = 6'd3,
        OP_MAC     = 6'd4,
        OP_AND     = 6'd5,
        OP_OR      = 6'd6,
        OP_XOR     = 6'd7,
        OP_SHL     = 6'd8,
        OP_SHR     = 6'd9,
        OP_CMP_GT  = 6'd10,
        OP_CMP_LT  = 6'd11,
        OP_CMP_EQ  = 6'd12,
        OP_LOAD    = 6'd13,
        OP_STORE   = 6'd14,
        OP_ACC_CLR = 6'd15,
        OP_PASS0   = 6'd16,
        OP_PASS1   = 6'd17
    } opcode_e;

    typedef enum logic [RF_ADDR_WIDTH-1:0] {
        SRC_RF  = 4'd0,
        SRC_N   = 4'd1,
        SRC_E   = 4'd2,
        SRC_S   = 4'd3,
        SRC_W   = 4'd4,
        SRC_SPM = 4'd5,
        SRC_IMM = 4'd6
    } src_sel_e;

    // One bit per output port
    typedef struct packed {
        logic loc;
        logic n;
        logic e;
        logic s;
        logic w;
    } route_mask_t;

    typedef struct packed {
        logic [13:0]                reserved;
        logic                       multicast;
        logic [COORD_WIDTH-1:0]     dest_y;
        logic [COORD_WIDTH-1:0]     dest_x;
        logic [PAYLOAD_WIDTH-1:0]   imm;
        logic                       pred_inv;
        logic                       pred_en;
        route_mask_t                route;
        logic [RF_ADDR_WIDTH-1:0]   dst;
        src_sel_e                   src1;
        src_sel_e                   src0;
        opcode_e                    op;
    } cfg_frame_t;

    typedef struct packed {
        logic                       multicast;
        logic [COORD_WIDTH-1:0]     dest_x;
        logic [COORD_WIDTH-1:0]     dest_y;
        logic [HDR_RSVD_WIDTH-1:0]  reserved;
        logic [PAYLOAD_WIDTH-1:0]   payload;
    } pe_packet_t;

    // Mesh word, seen either as a number or as a routed packet
    typedef union packed {
        logic signed [DATA_WIDTH-1:0] raw;
        pe_packet_t                   packet;
    } pe_word_u;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]  result;
        route_mask_t            route;
        logic                   multicast;
        logic [COORD_WIDTH-1:0] dest_x;
        logic [COORD_WIDTH-1:0] dest_y;
        logic                   valid;
    } pe_result_t;

endpackage

/* design/pe_alu.sv */
// ========================================
// PE ALU
// Single-cycle datapath with saturating
// add and subtract, 40-bit MAC, compares
// feeding the predicate flag, and the
// write enables for RF and scratchpad
// ========================================

`timescale 1ns/1ps

module pe_alu (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            accept,
    input  cgra_pkg::opcode_e               op,
    input  logic                            pred_en,
    input  logic                            pred_inv,
    input  logic [cgra_pkg::DATA_WIDTH-1:0] operand0,
    input  logic [cgra_pkg::DATA_WIDTH-1:0] operand1,
    input  logic [cgra_pkg::DATA_WIDTH-1:0] spm_rdata,
    output logic [cgra_pkg::DATA_WIDTH-1:0] result,
    output logic                            exec_en,
    output logic                            rf_we,
    output logic                            spm_we
);
    import cgra_pkg::*;

    localparam int EXT_WIDTH = ACC_WIDTH - DATA_WIDTH;

    logic signed [ACC_WIDTH-1:0] acc;
    logic                        pred_flag;

    logic signed [ACC_WIDTH-1:0] op0_ext;
    logic signed [ACC_WIDTH-1:0] op1_ext;
    logic signed [ACC_WIDTH-1:0] add_sum;
    logic signed [ACC_WIDTH-1:0] sub_diff;
    logic signed [ACC_WIDTH-1:0] mul_ext;
    logic signed [ACC_WIDTH-1:0] mac_sum;
    logic [DATA_WIDTH-1:0]       mul_lo;
    logic                        cmp_gt;
    logic                        cmp_lt;
    logic                        cmp_eq;
    logic                        writes_rf;

    function automatic logic [DATA_WIDTH-1:0] saturate(
        input logic signed [ACC_WIDTH-1:0] v
    );
        if (v > SAT_MAX) begin
            return SAT_MAX[DATA_WIDTH-1:0];
        end else if (v < SAT_MIN) begin
            return SAT_MIN[DATA_WIDTH-1:0];
        end
        return v[DATA_WIDTH-1:0];
    endfunction

    // ========================================
    // Arithmetic
    // ========================================
    assign op0_ext  = {{EXT_WIDTH{operand0[DATA_WIDTH-1]}}, operand0};
    assign op1_ext  = {{EXT_WIDTH{operand1[DATA_WIDTH-1]}}, operand1};
    assign add_sum  = op0_ext + op1_ext;
    assign sub_diff = op0_ext - op1_ext;

    // Only the low word of the product is kept
    assign mul_lo  = operand0 * operand1;
    assign mul_ext = {{EXT_WIDTH{mul_lo[DATA_WIDTH-1]}}, mul_lo};
    assign mac_sum = acc + mul_ext;

    // Unsigned compares
    assign cmp_gt = operand0 > operand1;
    assign cmp_lt = operand0 < operand1;
    assign cmp_eq = operand0 == operand1;

    always_comb begin
        case (op)
            OP_ADD:    result = saturate(add_sum);
            OP_SUB:    result = saturate(sub_diff);
            OP_MUL:    result = mul_lo;
            OP_MAC:    result = saturate(mac_sum);
            OP_AND:    result = operand0 & operand1;
            OP_OR:     result = operand0 | operand1;
            OP_XOR:    result = operand0 ^ operand1;
            OP_SHL:    result = operand0 << operand1[SHAMT_WIDTH-1:0];
            OP_SHR:    result = operand0 >> operand1[SHAMT_WIDTH-1:0];
            OP_CMP_GT: result = DATA_WIDTH'(cmp_gt);
            OP_CMP_LT: result = DATA_WIDTH'(cmp_lt);
            OP_CMP_EQ: result = DATA_WIDTH'(cmp_eq);
            OP_LOAD:   result = spm_rdata;
            OP_STORE:  result = operand0;
            OP_PASS0:  result = operand0;
            OP_PASS1:  result = operand1;
            default:   result = '0;
        endcase
    end

    // ========================================
    // Predicate and write enables
    // ========================================
    assign exec_en = pred_en ? (pred_flag ^ pred_inv) : 1'b1;

    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_MUL, OP_MAC, OP_AND, OP_OR, OP_XOR,
            OP_SHL, OP_SHR, OP_CMP_GT, OP_CMP_LT, OP_CMP_EQ,
            OP_LOAD, OP_PASS0, OP_PASS1: writes_rf = 1'b1;
            default:                     writes_rf = 1'b0;
        endcase
    end

    assign rf_we  = accept && exec_en && writes_rf;
    assign spm_we = accept && exec_en && (op == OP_STORE);

    // Accumulator takes the unsaturated value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc       <= '0;
            pred_flag <= 1'b0;
        end else if (accept && exec_en) begin
            case (op)
                OP_ADD:     acc <= add_sum;
                OP_SUB:     acc <= sub_diff;
                OP_MAC:     acc <= mac_sum;
                OP_ACC_CLR: acc <= '0;
                OP_CMP_GT:  pred_flag <= cmp_gt;
                OP_CMP_LT:  pred_flag <= cmp_lt;
                OP_CMP_EQ:  pred_flag <= cmp_eq;
                default: begin
                end
            endcase
        end
    end

    a_one_writer: assert property (
        @(posedge clk) disable iff (!rst_n) !(rf_we && spm_we)
    );

endmodule

/* design/pe_operand_select.sv */
// ========================================
// PE operand select
// Neighbor payload extraction and the two
// operand source multiplexers
// ========================================

`timescale 1ns/1ps

module pe_operand_select (
    input  cgra_pkg::src_sel_e                  src0,
    input  cgra_pkg::src_sel_e                  src1,
    input  logic [cgra_pkg::PAYLOAD_WIDTH-1:0]  imm,
    input  cgra_pkg::pe_word_u [3:0]            nbr_data,
    input  logic [3:0]                          nbr_valid,
    input  logic [cgra_pkg::DATA_WIDTH-1:0]     rf_rdata0,
    input  logic [cgra_pkg::DATA_WIDTH-1:0]     rf_rdata1,
    input  logic [cgra_pkg::DATA_WIDTH-1:0]     spm_rdata,
    output logic [cgra_pkg::DATA_WIDTH-1:0]     operand0,
    output logic [cgra_pkg::DATA_WIDTH-1:0]     operand1
);
    import cgra_pkg::*;

    localparam int EXT_WIDTH = DATA_WIDTH - PAYLOAD_WIDTH;

    // Index 0..3 is N, E, S, W
    logic [3:0][DATA_WIDTH-1:0] nbr_ext;
    logic [DATA_WIDTH-1:0]      imm_ext;

    function automatic logic [DATA_WIDTH-1:0] pick(
        input src_sel_e                   sel,
        input logic [DATA_WIDTH-1:0]      rf_val,
        input logic [3:0][DATA_WIDTH-1:0] nbr,
        input logic [DATA_WIDTH-1:0]      spm_val,
        input logic [DATA_WIDTH-1:0]      imm_val
    );
        case (sel)
            SRC_RF:  return rf_val;
            SRC_N:   return nbr[0];
            SRC_E:   return nbr[1];
            SRC_S:   return nbr[2];
            SRC_W:   return nbr[3];
            SRC_SPM: return spm_val;
            SRC_IMM: return imm_val;
            default: return '0;
        endcase
    endfunction

    // Signed payload, zero when the neighbor is idle
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (nbr_valid[i]) begin
                nbr_ext[i] = {{EXT_WIDTH{nbr_data[i].packet.payload[PAYLOAD_WIDTH-1]}},
                              nbr_data[i].packet.payload};
            end else begin
                nbr_ext[i] = '0;
            end
        end
    end

    assign imm_ext  = {{EXT_WIDTH{1'b0}}, imm};
    assign operand0 = pick(src0, rf_rdata0, nbr_ext, spm_rdata, imm_ext);
    assign operand1 = pick(src1, rf_rdata1, nbr_ext, spm_rdata, imm_ext);

endmodule

/* design/pe_regfile.sv */
// ========================================
// PE register file
// 16 entries, two combinational reads and
// one synchronous write
// ========================================

`timescale 1ns/1ps

module pe_regfile (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [cgra_pkg::RF_ADDR_WIDTH-1:0] raddr0,
    input  logic [cgra_pkg::RF_ADDR_WIDTH-1:0] raddr1,
    input  logic [cgra_pkg::RF_ADDR_WIDTH-1:0] waddr,
    input  logic                               we,
    input  logic [cgra_pkg::DATA_WIDTH-1:0]    wdata,
    output logic [cgra_pkg::DATA_WIDTH-1:0]    rdata0,
    output logic [cgra_pkg::DATA_WIDTH-1:0]    rdata1
);
    import cgra_pkg::*;

    localparam int RF_DEPTH = 2 ** RF_ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] regs [RF_DEPTH];

    // we already carries the accept qualifier
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];

    a_waddr_known: assert property (
        @(posedge clk) disable iff (!rst_n) we |-> !$isunknown(waddr)
    );

endmodule

/* design/pe_route_out.sv */
// ========================================
// PE output stage
// Registers the result once and builds the
// outgoing packet and per-port valids
// ========================================

`timescale 1ns/1ps

module pe_route_out (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    accept,
    input  logic                    exec_en,
    input  logic                    stall,
    input  cgra_pkg::pe_result_t    result_in,
    output cgra_pkg::pe_word_u      data_out,
    output cgra_pkg::route_mask_t   valid_out
);
    import cgra_pkg::*;

    pe_result_t res_q;

    // Capture on accept, drop valid on an idle cycle, hold on stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_q <= '0;
        end else if (accept) begin
            res_q       <= result_in;
            res_q.valid <= result_in.valid && exec_en;
        end else if (!stall) begin
            res_q.valid <= 1'b0;
        end
    end

    // ========================================
    // Packet assembly
    // ========================================
    always_comb begin
        data_out.packet.multicast = res_q.multicast;
        data_out.packet.dest_x    = res_q.dest_x;
        data_out.packet.dest_y    = res_q.dest_y;
        data_out.packet.reserved  = '0;
        data_out.packet.payload   = res_q.result[PAYLOAD_WIDTH-1:0];
    end

    assign valid_out = res_q.route & {$bits(route_mask_t){res_q.valid}};

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall |=> $stable(valid_out)
    );

endmodule

/* design/pe_scratchpad.sv */
// ========================================
// PE scratchpad memory
// Combinational read, write on the clock
// edge, depth set from the top level
// ========================================

`timescale 1ns/1ps

module pe_scratchpad #(
    parameter int SPM_DEPTH = 256
) (
    input  logic                            clk,
    input  logic [$clog2(SPM_DEPTH)-1:0]    addr,
    input  logic                            we,
    input  logic [cgra_pkg::DATA_WIDTH-1:0] wdata,
    output logic [cgra_pkg::DATA_WIDTH-1:0] rdata
);
    import cgra_pkg::*;

    logic [DATA_WIDTH-1:0] mem [SPM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Read port sees the old word during a write cycle
    assign rdata = mem[addr];

endmodule

/* tb/cgra_pe_tb.sv */
// ========================================
// CGRA processing element testbench
// Directed tests for arithmetic, MAC,
// predication, scratchpad, routing and
// back-pressure on the single PE
// ========================================

`timescale 1ns/1ps

module cgra_pe_tb;
    import cgra_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_FRAMES = 80;
    localparam int MARGIN_CYC = 100;
    localparam route_mask_t TO_LOCAL = 5'b10000;

    logic        clk;
    logic        rst_n;
    cfg_frame_t  config_frame;
    logic        config_valid;
    pe_word_u    nbr_word [4];
    logic [3:0]  nbr_vld;
    pe_word_u    data_out_n;
    pe_word_u    data_out_e;
    pe_word_u    data_out_s;
    pe_word_u    data_out_w;
    pe_word_u    data_out_local;
    logic        valid_out_n;
    logic        valid_out_e;
    logic        valid_out_s;
    logic        valid_out_w;
    logic        valid_out_local;
    logic        ready_in;
    logic        ready_out;

    integer                      seed = 32'hc9625c55;
    int                          frames_issued = 0;
    logic signed [ACC_WIDTH-1:0] acc_model;

    // Neighbor index 0..3 is N, E, S, W
    cgra_pe #(
        .SPM_DEPTH (256)
    ) dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .config_frame    (config_frame),
        .config_valid    (config_valid),
        .data_in_n       (nbr_word[0]),
        .data_in_e       (nbr_word[1]),
        .data_in_s       (nbr_word[2]),
        .data_in_w       (nbr_word[3]),
        .valid_in_n      (nbr_vld[0]),
        .valid_in_e      (nbr_vld[1]),
        .valid_in_s      (nbr_vld[2]),
        .valid_in_w      (nbr_vld[3]),
        .data_out_n      (data_out_n),
        .data_out_e      (data_out_e),
        .data_out_s      (data_out_s),
        .data_out_w      (data_out_w),
        .data_out_local  (data_out_local),
        .valid_out_n     (valid_out_n),
        .valid_out_e     (valid_out_e),
        .valid_out_s     (valid_out_s),
        .valid_out_w     (valid_out_w),
        .valid_out_local (valid_out_local),
        .ready_in        (ready_in),
        .ready_out       (ready_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Eight cycles allowed per frame, plus slack for reset and stalls
    initial begin
        #((MAX_FRAMES * 8 + MARGIN_CYC) * CLK_PERIOD);
        $display("Timeout: the run did not finish within the frame budget");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic [4:0] valids();
        return {valid_out_local, valid_out_n, valid_out_e, valid_out_s, valid_out_w};
    endfunction

    function automatic cfg_frame_t make_frame(
        input opcode_e          op,
        input src_sel_e         s0,
        input src_sel_e         s1,
        input logic [3:0]       dst,
        input logic [15:0]      imm,
        input route_mask_t      route
    );
        cfg_frame_t f;
        f           = '0;
        f.op        = op;
        f.src0      = s0;
        f.src1      = s1;
        f.dst       = dst;
        f.imm       = imm;
        f.route     = route;
        f.multicast = 1'b1;
        f.dest_x    = 4'h9;
        f.dest_y    = 4'h4;
        return f;
    endfunction

    // Saturate to the signed 32-bit range
    function automatic logic [31:0] clamp32(input logic signed [ACC_WIDTH-1:0] v);
        if (v > SAT_MAX) begin
            return 32'h7fff_ffff;
        end
        if (v < SAT_MIN) begin
            return 32'h8000_0000;
        end
        return v[31:0];
    endfunction

    task automatic issue(input cfg_frame_t f);
        @(negedge clk);
        config_frame = f;
        config_valid = 1'b1;
        @(posedge clk);
        while (!ready_out) begin
            @(posedge clk);
        end
        frames_issued++;
        @(negedge clk);
        config_valid = 1'b0;
    endtask

    // Payload is the low half of the result, header comes from the frame
    task automatic check_out(input cfg_frame_t f, input logic [31:0] res, input logic executed);
        logic [31:0] exp_word;
        exp_word = {f.multicast, f.dest_x, f.dest_y, 7'b0, res[15:0]};
        check("valid_out", {27'h0, valids()}, executed ? {27'h0, f.route} : 32'h0);
        if (executed) begin
            check("data_out_local", data_out_local, exp_word);
            check("data_out_n", data_out_n, exp_word);
            check("data_out_e", data_out_e, exp_word);
            check("data_out_s", data_out_s, exp_word);
            check("data_out_w", data_out_w, exp_word);
        end
    endtask

    task automatic run(input cfg_frame_t f, input logic [31:0] res, input logic executed);
        issue(f);
        check_out(f, res, executed);
    endtask

    task automatic set_r0(input logic [15:0] val);
        run(make_frame(OP_PASS0, SRC_IMM, SRC_IMM, 4'd0, val, TO_LOCAL), {16'h0, val}, 1'b1);
    endtask

    // RF operand always reads r0, r15 is the throwaway destination
    task automatic read_r0(input logic [31:0] exp);
        run(make_frame(OP_PASS0, SRC_RF, SRC_IMM, 4'd15, 16'h0, TO_LOCAL), exp, 1'b1);
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic test_arith();
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  sh;
        a  = {16'h0, 16'($random(seed))};
        b  = {16'h0, 16'($random(seed))};
        sh = 4'($random(seed));
        set_r0(a[15:0]);
        run(make_frame(OP_ADD, SRC_RF, SRC_IMM, 4'd1, b[15:0], TO_LOCAL), a + b, 1'b1);
        run(make_frame(OP_SUB, SRC_RF, SRC_IMM, 4'd1, b[15:0], TO_LOCAL), a - b, 1'b1);
        run(make_frame(OP_MUL, SRC_RF, SRC_IMM, 4'd1, b[15:0], 5'b11111), a * b, 1'b1);
        run(make_frame(OP_AND, SRC_RF, SRC_IMM, 4'd1, b[15:0], TO_LOCAL), a & b, 1'b1);
        run(make_frame(OP_OR, SRC_RF, SRC_IMM, 4'd1, b[15:0], TO_LOCAL), a | b, 1'b1);
        run(make_frame(OP_XOR, SRC_RF, SRC_IMM, 4'd1, b[15:0], TO_LOCAL), a ^ b, 1'b1);
        run(make_frame(OP_SHL, SRC_RF, SRC_IMM, 4'd1, {12'h0, sh}, TO_LOCAL), a << sh, 1'b1);
        run(make_frame(OP_SHR, SRC_RF, SRC_IMM, 4'd1, {12'h0, sh}, TO_LOCAL), a >> sh, 1'b1);
        run(make_frame(OP_ADD, SRC_RF, SRC_RF, 4'd2, 16'h0, TO_LOCAL), a + a, 1'b1);
        read_r0(a);
    endtask

    task automatic test_sat_mac();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        // Build 0x7fffffff in r0, then add it to itself
        set_r0(16'hffff);
        run(make_frame(OP_SHL, SRC_RF, SRC_IMM, 4'd0, 16'd15, TO_LOCAL), 32'h7fff8000, 1'b1);
        run(make_frame(OP_OR, SRC_RF, SRC_IMM, 4'd0, 16'h7fff, TO_LOCAL), 32'h7fffffff, 1'b1);
        run(make_frame(OP_ADD, SRC_RF, SRC_RF, 4'd1, 16'h0, TO_LOCAL), 32'h7fffffff, 1'b1);
        // 0x80000000 minus one clamps at the minimum
        set_r0(16'h0001);
        run(make_frame(OP_SHL, SRC_RF, SRC_IMM, 4'd0, 16'd15, TO_LOCAL), 32'h00008000, 1'b1);
        run(make_frame(OP_SHL, SRC_RF, SRC_IMM, 4'd0, 16'd15, TO_LOCAL), 32'h40000000, 1'b1);
        run(make_frame(OP_SHL, SRC_RF, SRC_IMM, 4'd0, 16'd1, TO_LOCAL), 32'h80000000, 1'b1);
        run(make_frame(OP_SUB, SRC_RF, SRC_IMM, 4'd1, 16'd1, TO_LOCAL), 32'h80000000, 1'b1);

        run(make_frame(OP_ACC_CLR, SRC_IMM, SRC_IMM, 4'd0, 16'h0, TO_LOCAL), 32'h0, 1'b1);
        acc_model = '0;
        a = {16'h0, 16'($random(seed))};
        set_r0(a[15:0]);
        repeat (4) begin
            b = {16'h0, 16'($random(seed))};
            p = a * b;
            acc_model = acc_model + $signed(p);
            run(make_frame(OP_MAC, SRC_RF, SRC_IMM, 4'd1, b[15:0], TO_LOCAL),
                clamp32(acc_model), 1'b1);
        end

        // Fresh chain that runs past the positive limit
        run(make_frame(OP_ACC_CLR, SRC_IMM, SRC_IMM, 4'd0, 16'h0, TO_LOCAL), 32'h0, 1'b1);
        acc_model = '0;
        set_r0(16'h7fff);
        repeat (3) begin
            acc_model = acc_model + $signed(32'h7fff * 32'h7fff);
            run(make_frame(OP_MAC, SRC_RF, SRC_IMM, 4'd1, 16'h7fff, TO_LOCAL),
                clamp32(acc_model), 1'b1);
        end
        read_r0(32'h7fff);
    endtask

    task automatic test_pred();
        cfg_frame_t  f;
        cfg_frame_t  g;
        logic [31:0] x;
        logic [31:0] y;
        x = {16'h0, 16'h8000 | 16'($random(seed))};
        y = x >> 1;
        set_r0(x[15:0]);
        run(make_frame(OP_CMP_GT, SRC_RF, SRC_IMM, 4'd7, y[15:0], TO_LOCAL), 32'd1, 1'b1);
        f          = make_frame(OP_ADD, SRC_RF, SRC_IMM, 4'd0, y[15:0], TO_LOCAL);
        f.pred_en  = 1'b1;
        f.pred_inv = 1'b1;
        run(f, 32'h0, 1'b0);
        read_r0(x);
        f.pred_inv = 1'b0;
        run(f, x + y, 1'b1);
        read_r0(x + y);
        // False compare clears the flag
        run(make_frame(OP_CMP_EQ, SRC_RF, SRC_IMM, 4'd7, y[15:0], TO_LOCAL), 32'd0, 1'b1);
        run(f, 32'h0, 1'b0);
        read_r0(x + y);
        run(make_frame(OP_CMP_LT, SRC_IMM, SRC_RF, 4'd7, y[15:0], TO_LOCAL), 32'd1, 1'b1);
        // Squashed compare would have cleared the flag
        g          = make_frame(OP_CMP_GT, SRC_IMM, SRC_RF, 4'd7, 16'h0, TO_LOCAL);
        g.pred_en  = 1'b1;
        g.pred_inv = 1'b1;
        run(g, 32'h0, 1'b0);
        run(f, x + y + y, 1'b1);
        read_r0(x + y + y);
    endtask

    task automatic test_spm();
        logic [15:0] v0;
        logic [15:0] v1;
        logic [7:0]  addr;
        v0   = 16'($random(seed));
        v1   = 16'($random(seed));
        addr = 8'($random(seed));
        set_r0(v0);
        run(make_frame(OP_STORE, SRC_RF, SRC_IMM, 4'd0, {8'h0, addr}, TO_LOCAL), v0, 1'b1);
        set_r0(v1);
        run(make_frame(OP_STORE, SRC_RF, SRC_IMM, 4'd0, {8'h0, addr ^ 8'h01}, TO_LOCAL),
            v1, 1'b1);
        run(make_frame(OP_LOAD, SRC_IMM, SRC_IMM, 4'd0, {8'h0, addr}, TO_LOCAL), v0, 1'b1);
        read_r0({16'h0, v0});
        run(make_frame(OP_PASS0, SRC_SPM, SRC_IMM, 4'd3, {8'h0, addr ^ 8'h01}, TO_LOCAL),
            v1, 1'b1);
        run(make_frame(OP_PASS1, SRC_IMM, SRC_SPM, 4'd3, {8'h0, addr}, TO_LOCAL), v0, 1'b1);
    endtask

    task automatic test_route();
        cfg_frame_t  f;
        logic [15:0] pay;
        for (int i = 0; i < 4; i++) begin
            pay                     = 16'h8000 | 16'($random(seed));
            nbr_word[i].raw         = $random(seed);
            nbr_word[i].packet.payload = pay;
            nbr_vld[i]              = 1'b1;
            run(make_frame(OP_SHR, src_sel_e'(i + 1), SRC_IMM, 4'd4, 16'd8, TO_LOCAL),
                {16'hffff, pay} >> 8, 1'b1);
        end
        for (int r = 0; r < 5; r++) begin
            f           = make_frame(OP_PASS0, SRC_IMM, SRC_IMM, 4'd15, 16'($random(seed)),
                                     route_mask_t'(5'b00001 << r));
            f.multicast = r[0];
            f.dest_x    = 4'(r);
            f.dest_y    = ~4'(r);
            run(f, {16'h0, f.imm}, 1'b1);
        end
        // Idle neighbor reads as zero whatever its data
        nbr_vld[1] = 1'b0;
        run(make_frame(OP_PASS0, SRC_E, SRC_IMM, 4'd15, 16'h0, TO_LOCAL), 32'h0, 1'b1);
        nbr_vld = 4'h0;
    endtask

    task automatic test_stall();
        cfg_frame_t  f;
        logic [15:0] v;
        v = 16'($random(seed));
        set_r0(v);
        f = make_frame(OP_PASS0, SRC_RF, SRC_IMM, 4'd15, 16'h0, 5'b10101);
        run(f, {16'h0, v}, 1'b1);
        // Pending frame must not be taken while the router is busy
        ready_in     = 1'b0;
        config_frame = make_frame(OP_PASS0, SRC_IMM, SRC_IMM, 4'd0, ~v, TO_LOCAL);
        config_valid = 1'b1;
        repeat (3) begin
            @(posedge clk);
            check("ready_out low", {31'h0, ready_out}, 32'h0);
            @(negedge clk);
            check_out(f, {16'h0, v}, 1'b1);
        end
        config_valid = 1'b0;
        ready_in     = 1'b1;
        @(posedge clk);
        check("ready_out high", {31'h0, ready_out}, 32'h1);
        @(negedge clk);
        check("valid after idle", {27'h0, valids()}, 32'h0);
        read_r0({16'h0, v});
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        rst_n        = 1'b0;
        config_frame = '0;
        config_valid = 1'b0;
        ready_in     = 1'b1;
        nbr_vld      = 4'h0;
        for (int i = 0; i < 4; i++) begin
            nbr_word[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check("valid after reset", {27'h0, valids()}, 32'h0);
        check("data after reset", data_out_local, 32'h0);
        read_r0(32'h0);

        test_arith();
        test_sat_mac();
        test_pred();
        test_spm();
        test_route();
        test_stall();

        $display("%0d frames issued", frames_issued);
        $display("all tests passed");
        $finish;
    end

endmodule

/* vlog.f */
design/cgra_pkg.sv
design/pe_regfile.sv
design/pe_scratchpad.sv
design/pe_operand_select.sv
design/pe_alu.sv
design/pe_route_out.sv
design/cgra_pe.sv
tb/cgra_pe_tb.sv
